// File: hdl/csr_pkg.sv
package csr_pkg;

  //////////////////////////////////////////////////
  // CSR addresses
  //////////////////////////////////////////////////

  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_CYCLE         = 12'hC00,  // User read-only aliases
    CSR_INSTRET       = 12'hC02,
    CSR_CYCLEH        = 12'hC80,
    CSR_INSTRETH      = 12'hC82,
    CSR_MIMPID        = 12'hF13
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////////////////////////
  // Register layouts
  //////////////////////////////////////////////////

  localparam logic [1:0] PRIV_LVL_M = 2'b11;  // Only machine mode exists
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  typedef struct packed {
    logic [18:0] zero3;  // 31:13
    logic [1:0]  mpp;    // 12:11, hardwired to M
    logic [2:0]  zero2;
    logic        mpie;   // 7
    logic [2:0]  zero1;
    logic        mie;    // 3
    logic [2:0]  zero0;
  } mstatus_t;

  typedef struct packed {
    logic        interrupt;       // Set for asynchronous causes
    logic [30:0] exception_code;
  } mcause_t;

  typedef struct packed {
    logic [23:0] addr;   // Base, 256 byte aligned
    logic [5:0]  zero0;
    logic [1:0]  mode;   // Only bit 0 is writable
  } mtvec_t;

  //////////////////////////////////////////////////
  // Request structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic     valid;
    csr_op_e  op;
    csr_num_e addr;
  } csr_rd_t;

  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    csr_num_e    addr;
    logic [31:0] wdata;
    logic [31:0] old_value;  // Value returned by the earlier read
  } csr_wr_t;

  typedef struct packed {
    logic        save;  // Trap entry
    logic        mret;  // Trap return
    mcause_t     cause;
    logic [31:0] epc;
  } trap_req_t;

  //////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////

  localparam logic [31:0] MISA_VALUE =
      (32'(1) << 2)    // C
    | (32'(1) << 8)    // I
    | (32'(1) << 12)   // M
    | (32'(1) << 30);  // MXL = 1, 32 bit

  localparam logic [31:0] IRQ_MASK           = 32'h0000_0888;  // MSI, MTI, MEI
  localparam logic [31:0] MCOUNTINHIBIT_MASK = 32'h0000_0005;  // CY and IR

endpackage

// File: hdl/csr_write_ctrl.sv
`timescale 1ns/100ps

module csr_write_ctrl import csr_pkg::*; (
  input  csr_wr_t     wr_req_i,  // Write request from the core
  output logic [31:0] wdata_o,   // Final value after the read-modify-write
  output logic        we_o,      // One strobe for all banks
  output csr_num_e    waddr_o    // Banks decode this against their own registers
);

  //////////////////////////////////////////////////
  // Operation rules
  //////////////////////////////////////////////////

  // Set and clear work on the value the core read earlier
  always_comb begin
    case (wr_req_i.op)
      CSR_OP_WRITE: begin
        wdata_o = wr_req_i.wdata;
      end
      CSR_OP_SET: begin
        wdata_o = wr_req_i.old_value | wr_req_i.wdata;
      end
      CSR_OP_CLEAR: begin
        wdata_o = wr_req_i.old_value & ~wr_req_i.wdata;
      end
      default: begin
        wdata_o = wr_req_i.wdata;  // Read, data unused since we_o stays low
      end
    endcase
  end

  // A read op never writes
  assign we_o = wr_req_i.valid && (wr_req_i.op != CSR_OP_READ);

  // Address goes out unchanged, legality is the read side's job
  assign waddr_o = wr_req_i.addr;

endmodule

// File: hdl/trap_csrs.sv
`timescale 1ns/100ps

module trap_csrs import csr_pkg::*; #(
  parameter logic [31:0] MTVEC_RESET_ADDR = 32'h0000_0800
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] wdata_i,         // Write data after set/clear
  input  logic        we_i,
  input  csr_num_e    waddr_i,
  input  trap_req_t   trap_i,          // Trap entry and mret pulses
  output mstatus_t    mstatus_o,
  output logic [31:0] mie_o,
  output mtvec_t      mtvec_o,
  output logic [31:0] mscratch_o,
  output logic [31:0] mepc_o,
  output mcause_t     mcause_o,
  output logic        m_irq_enable_o
);

  // Base from the parameter, direct mode
  localparam mtvec_t MTVEC_RESET_VAL = '{
    addr:  MTVEC_RESET_ADDR[31:8],
    zero0: 6'b0,
    mode:  2'b00
  };

  logic        mstatus_mie_q;   // Global interrupt enable
  logic        mstatus_mpie_q;  // Enable saved on trap entry
  logic [31:0] mie_q;
  mtvec_t      mtvec_q;
  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;
  mcause_t     mcause_q;

  logic mstatus_we, mie_we, mtvec_we, mscratch_we, mepc_we, mcause_we;

  // Address decode, own registers only
  assign mstatus_we  = we_i && (waddr_i == CSR_MSTATUS);
  assign mie_we      = we_i && (waddr_i == CSR_MIE);
  assign mtvec_we    = we_i && (waddr_i == CSR_MTVEC);
  assign mscratch_we = we_i && (waddr_i == CSR_MSCRATCH);
  assign mepc_we     = we_i && (waddr_i == CSR_MEPC);
  assign mcause_we   = we_i && (waddr_i == CSR_MCAUSE);

  //////////////////////////////////////////////////
  // Register update
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mtvec_q        <= MTVEC_RESET_VAL;
      mscratch_q     <= '0;
      mepc_q         <= '0;
      mcause_q       <= '0;
    end else begin
      // Trap entry, then mret, then software
      if (trap_i.save) begin
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;                  // Interrupts off in handler
      end else if (trap_i.mret) begin
        mstatus_mie_q  <= mstatus_mpie_q;        // Restore saved enable
        mstatus_mpie_q <= 1'b1;
      end else if (mstatus_we) begin
        mstatus_mie_q  <= wdata_i[MSTATUS_MIE_BIT];
        mstatus_mpie_q <= wdata_i[MSTATUS_MPIE_BIT];
      end

      if (trap_i.save) begin
        mepc_q   <= {trap_i.epc[31:1], 1'b0};
        mcause_q <= trap_i.cause;
      end else begin
        if (mepc_we) begin
          mepc_q <= {wdata_i[31:1], 1'b0};       // Halfword aligned
        end
        if (mcause_we) begin
          mcause_q <= wdata_i;
        end
      end

      // Not touched by traps
      if (mie_we) begin
        mie_q <= wdata_i & IRQ_MASK;
      end
      if (mtvec_we) begin
        mtvec_q <= '{addr: wdata_i[31:8], zero0: 6'b0, mode: {1'b0, wdata_i[0]}};
      end
      if (mscratch_we) begin
        mscratch_q <= wdata_i;
      end
    end
  end

  // Only mie and mpie are stored, mpp reads as M
  always_comb begin
    mstatus_o      = '0;
    mstatus_o.mpp  = PRIV_LVL_M;
    mstatus_o.mpie = mstatus_mpie_q;
    mstatus_o.mie  = mstatus_mie_q;
  end

  assign mie_o          = mie_q;
  assign mtvec_o        = mtvec_q;
  assign mscratch_o     = mscratch_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign m_irq_enable_o = mstatus_mie_q;

endmodule

// File: hdl/hpm_counters.sv
`timescale 1ns/100ps

module hpm_counters import csr_pkg::*; #(
  parameter int COUNTER_WIDTH = 64  // 32 or 64
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [31:0]              wdata_i,
  input  logic                     we_i,
  input  csr_num_e                 waddr_i,
  input  logic                     instr_ret_i,     // One instruction retires
  output logic [COUNTER_WIDTH-1:0] mcycle_o,
  output logic [COUNTER_WIDTH-1:0] minstret_o,
  output logic [31:0]              mcountinhibit_o
);

  localparam bit HAS_UPPER = (COUNTER_WIDTH > 32);  // Upper half writable

  logic [COUNTER_WIDTH-1:0] mcycle_q, minstret_q;
  logic [31:0]              mcountinhibit_q;

  logic mcycle_wr_lo, mcycle_wr_hi, minstret_wr_lo, minstret_wr_hi;
  logic mcountinhibit_we;

  // Write priority: low half, high half, then count
  function automatic logic [COUNTER_WIDTH-1:0] cnt_next(
    input logic [COUNTER_WIDTH-1:0] cnt_q,
    input logic                     wr_lo,
    input logic                     wr_hi,
    input logic [31:0]              wdata,
    input logic                     inc
  );
    logic [63:0] cnt_ext;
    cnt_ext = 64'(cnt_q);
    if (wr_lo) begin
      cnt_ext[31:0] = wdata;
    end else if (wr_hi) begin
      cnt_ext[63:32] = wdata;
    end else if (inc) begin
      cnt_ext = cnt_ext + 64'd1;
    end
    return cnt_ext[COUNTER_WIDTH-1:0];
  endfunction

  // Only machine addresses write, user aliases are read-only
  assign mcycle_wr_lo     = we_i && (waddr_i == CSR_MCYCLE);
  assign mcycle_wr_hi     = we_i && (waddr_i == CSR_MCYCLEH) && HAS_UPPER;
  assign minstret_wr_lo   = we_i && (waddr_i == CSR_MINSTRET);
  assign minstret_wr_hi   = we_i && (waddr_i == CSR_MINSTRETH) && HAS_UPPER;
  assign mcountinhibit_we = we_i && (waddr_i == CSR_MCOUNTINHIBIT);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q        <= '0;
      minstret_q      <= '0;
      mcountinhibit_q <= MCOUNTINHIBIT_MASK;  // Counters stopped out of reset
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, mcycle_wr_lo, mcycle_wr_hi, wdata_i,
                             !mcountinhibit_q[0]);
      minstret_q <= cnt_next(minstret_q, minstret_wr_lo, minstret_wr_hi, wdata_i,
                             !mcountinhibit_q[2] && instr_ret_i);
      if (mcountinhibit_we) begin
        mcountinhibit_q <= wdata_i & MCOUNTINHIBIT_MASK;
      end
    end
  end

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mcountinhibit_o = mcountinhibit_q;

endmodule

// File: hdl/csr_read_mux.sv
`timescale 1ns/100ps

module csr_read_mux import csr_pkg::*; #(
  parameter int COUNTER_WIDTH = 64
) (
  input  csr_rd_t                  rd_req_i,
  input  logic [31:0]              mip_i,
  input  logic [31:0]              mstatus_i,
  input  logic [31:0]              mie_i,
  input  logic [31:0]              mtvec_i,
  input  logic [31:0]              mscratch_i,
  input  logic [31:0]              mepc_i,
  input  logic [31:0]              mcause_i,
  input  logic [COUNTER_WIDTH-1:0] mcycle_i,
  input  logic [COUNTER_WIDTH-1:0] minstret_i,
  input  logic [31:0]              mcountinhibit_i,
  output logic [31:0]              rdata_o,
  output logic                     illegal_o,      // Unknown CSR or write to read-only
  output logic                     counter_rd_o    // Any counter half or alias
);

  logic [63:0] mcycle_ext, minstret_ext;  // Upper half zero for 32 bit counters
  logic        unknown;
  logic        is_counter;
  logic        ro_write;

  assign mcycle_ext   = 64'(mcycle_i);
  assign minstret_ext = 64'(minstret_i);

  //////////////////////////////////////////////////
  // Read select
  //////////////////////////////////////////////////

  always_comb begin
    unknown    = 1'b0;
    is_counter = 1'b0;
    case (rd_req_i.addr)
      CSR_MSTATUS:       rdata_o = mstatus_i;
      CSR_MISA:          rdata_o = MISA_VALUE;
      CSR_MIE:           rdata_o = mie_i;
      CSR_MTVEC:         rdata_o = mtvec_i;
      CSR_MCOUNTINHIBIT: rdata_o = mcountinhibit_i;
      CSR_MSCRATCH:      rdata_o = mscratch_i;
      CSR_MEPC:          rdata_o = mepc_i;
      CSR_MCAUSE:        rdata_o = mcause_i;
      CSR_MIP:           rdata_o = mip_i & IRQ_MASK;  // Implemented lines only
      CSR_MTVAL,
      CSR_MIMPID:        rdata_o = '0;
      CSR_MCYCLE, CSR_CYCLE: begin
        rdata_o    = mcycle_ext[31:0];
        is_counter = 1'b1;
      end
      CSR_MCYCLEH, CSR_CYCLEH: begin
        rdata_o    = mcycle_ext[63:32];
        is_counter = 1'b1;
      end
      CSR_MINSTRET, CSR_INSTRET: begin
        rdata_o    = minstret_ext[31:0];
        is_counter = 1'b1;
      end
      CSR_MINSTRETH, CSR_INSTRETH: begin
        rdata_o    = minstret_ext[63:32];
        is_counter = 1'b1;
      end
      default: begin
        rdata_o = '0;
        unknown = 1'b1;
      end
    endcase
  end

  // Bits 11:10 both set mark a read-only CSR
  assign ro_write = (rd_req_i.op != CSR_OP_READ) && (rd_req_i.addr[11:10] == 2'b11);

  assign illegal_o    = rd_req_i.valid && (unknown || ro_write);
  assign counter_rd_o = rd_req_i.valid && is_counter;

endmodule

// File: hdl/csr_file.sv
`timescale 1ns/100ps

module csr_file import csr_pkg::*; #(
  parameter int          COUNTER_WIDTH    = 64,
  parameter logic [31:0] MTVEC_RESET_ADDR = 32'h0000_0800
) (
  input  logic        clk,
  input  logic        rst_n,
  input  csr_rd_t     rd_req_i,        // Combinational read port
  input  csr_wr_t     wr_req_i,        // Write at the edge where valid is high
  input  trap_req_t   trap_i,
  input  logic        instr_ret_i,
  input  logic [31:0] mip_i,
  output logic [31:0] rdata_o,
  output logic        illegal_o,
  output logic        counter_rd_o,
  output logic [31:0] mie_o,
  output logic [31:0] mepc_o,
  output mtvec_t      mtvec_o,
  output logic        m_irq_enable_o
);

  logic [31:0]              wdata;
  logic                     we;
  csr_num_e                 waddr;
  mstatus_t                 mstatus;
  logic [31:0]              mscratch;
  mcause_t                  mcause;
  logic [COUNTER_WIDTH-1:0] mcycle, minstret;
  logic [31:0]              mcountinhibit;

  //////////////////////////////////////////////////
  // Write side
  //////////////////////////////////////////////////

  csr_write_ctrl u_write_ctrl (
    .wr_req_i (wr_req_i),
    .wdata_o  (wdata),
    .we_o     (we),
    .waddr_o  (waddr)
  );

  trap_csrs #(
    .MTVEC_RESET_ADDR (MTVEC_RESET_ADDR)
  ) u_trap_csrs (
    .clk            (clk),
    .rst_n          (rst_n),
    .wdata_i        (wdata),
    .we_i           (we),
    .waddr_i        (waddr),
    .trap_i         (trap_i),
    .mstatus_o      (mstatus),
    .mie_o          (mie_o),
    .mtvec_o        (mtvec_o),
    .mscratch_o     (mscratch),
    .mepc_o         (mepc_o),
    .mcause_o       (mcause),
    .m_irq_enable_o (m_irq_enable_o)
  );

  hpm_counters #(
    .COUNTER_WIDTH (COUNTER_WIDTH)
  ) u_hpm_counters (
    .clk             (clk),
    .rst_n           (rst_n),
    .wdata_i         (wdata),
    .we_i            (we),
    .waddr_i         (waddr),
    .instr_ret_i     (instr_ret_i),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mcountinhibit_o (mcountinhibit)
  );

  //////////////////////////////////////////////////
  // Read side
  //////////////////////////////////////////////////

  csr_read_mux #(
    .COUNTER_WIDTH (COUNTER_WIDTH)
  ) u_read_mux (
    .rd_req_i        (rd_req_i),
    .mip_i           (mip_i),
    .mstatus_i       (mstatus),     // Layouts go over as plain words
    .mie_i           (mie_o),
    .mtvec_i         (mtvec_o),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc_o),
    .mcause_i        (mcause),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mcountinhibit_i (mcountinhibit),
    .rdata_o         (rdata_o),
    .illegal_o       (illegal_o),
    .counter_rd_o    (counter_rd_o)
  );

endmodule

// File: verification/csr_file_sva.sv
`timescale 1ns/100ps

module csr_file_sva import csr_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input csr_rd_t     rd_req_i,
  input csr_wr_t     wr_req_i,
  input trap_req_t   trap_i,
  input logic        illegal_o,
  input logic        counter_rd_o,
  input logic        m_irq_enable_o,
  input logic [31:0] mie_o,
  input logic [31:0] mepc_o
);

  // MSI, MTI and MEI
  localparam logic [31:0] IRQ_BITS = (32'd1 << 3) | (32'd1 << 7) | (32'd1 << 11);

  int unsigned error_count = 0;  // Failed assertions so far

  //////////////////////////////////////////////////
  // Read port flags
  //////////////////////////////////////////////////

  flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
      !rd_req_i.valid |-> !illegal_o && !counter_rd_o)
    else begin
      error_count++;
      $error("illegal_o or counter_rd_o high without a valid read");
    end

  // Non-read op on a read-only address
  ro_write_illegal: assert property (@(posedge clk) disable iff (!rst_n)
      rd_req_i.valid && (rd_req_i.op != CSR_OP_READ) && (rd_req_i.addr[11:10] == 2'b11)
      |-> illegal_o)
    else begin
      error_count++;
      $error("Write op to a read-only CSR was not flagged illegal");
    end

  //////////////////////////////////////////////////
  // Register updates
  //////////////////////////////////////////////////

  trap_entry: assert property (@(posedge clk) disable iff (!rst_n)
      trap_i.save |=> !m_irq_enable_o && (mepc_o == {$past(trap_i.epc[31:1]), 1'b0}))
    else begin
      error_count++;
      $error("Trap entry did not load mepc or clear the interrupt enable");
    end

  mie_write_masked: assert property (@(posedge clk) disable iff (!rst_n)
      wr_req_i.valid && (wr_req_i.op == CSR_OP_WRITE) && (wr_req_i.addr == CSR_MIE)
      |=> mie_o == ($past(wr_req_i.wdata) & IRQ_BITS))
    else begin
      error_count++;
      $error("mie does not hold the masked write data");
    end

endmodule

// File: verification/csr_file_tb.sv
`timescale 1ns/100ps

module csr_file_tb import csr_pkg::*; ();

  localparam logic [31:0] MTVEC_BASE   = 32'h0000_1000;
  localparam logic [31:0] IRQ_BITS     = (32'd1 << 3) | (32'd1 << 7) | (32'd1 << 11);
  localparam logic [31:0] INHIBIT_BITS = 32'h0000_0005;  // CY and IR
  localparam logic [31:0] MISA_EXP     = 32'h4000_1104;  // MXL 1, M, I, C
  localparam int          TIMEOUT      = 50;             // Cycles per wait loop

  localparam logic [11:0] KEPT_ADDRS [19] = '{
    12'h300, 12'h301, 12'h304, 12'h305, 12'h320, 12'h340, 12'h341, 12'h342, 12'h343,
    12'h344, 12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hC00, 12'hC02, 12'hC80, 12'hC82,
    12'hF13
  };
  localparam logic [11:0] UNKNOWN_ADDRS [5] = '{12'h000, 12'h302, 12'h7B0, 12'hB01, 12'hFFF};

  logic        clk;
  logic        rst_n;
  csr_rd_t     rd_req;
  csr_wr_t     wr_req;
  trap_req_t   trap_req;
  logic        instr_ret;
  logic [31:0] mip;
  logic [31:0] rdata, mie_o, mepc_o;
  logic        illegal, counter_rd, m_irq_enable_o;
  mtvec_t      mtvec_o;

  logic [31:0] rd_data;                            // Sampled at the falling edge
  logic        rd_illegal, rd_counter;
  logic [31:0] model_scratch, model_mie, model_inhibit;
  logic [31:0] data, old, epc, prev;
  logic        prev_mie, pending_ret, exp_flag;
  csr_op_e     op;

  csr_file #(
    .COUNTER_WIDTH    (64),
    .MTVEC_RESET_ADDR (MTVEC_BASE)
  ) u_csr_file (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_req_i       (rd_req),
    .wr_req_i       (wr_req),
    .trap_i         (trap_req),
    .instr_ret_i    (instr_ret),
    .mip_i          (mip),
    .rdata_o        (rdata),
    .illegal_o      (illegal),
    .counter_rd_o   (counter_rd),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

  bind csr_file csr_file_sva u_csr_file_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .rd_req_i       (rd_req_i),
    .wr_req_i       (wr_req_i),
    .trap_i         (trap_i),
    .illegal_o      (illegal_o),
    .counter_rd_o   (counter_rd_o),
    .m_irq_enable_o (m_irq_enable_o),
    .mie_o          (mie_o),
    .mepc_o         (mepc_o)
  );

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // CSR instruction semantics on the old value
  function automatic logic [31:0] apply_op(input csr_op_e o, input logic [31:0] d,
                                           input logic [31:0] prior);
    case (o)
      CSR_OP_SET:   return prior | d;
      CSR_OP_CLEAR: return prior & ~d;
      default:      return d;
    endcase
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
      else abort_run($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
  endtask

  // Read held from one rising edge, sampled at the falling edge
  task automatic read_csr(input logic [11:0] addr, input csr_op_e o);
    @(posedge clk);
    rd_req <= '{valid: 1'b1, op: o, addr: csr_num_e'(addr)};
    @(negedge clk);
    rd_data    = rdata;
    rd_illegal = illegal;
    rd_counter = counter_rd;
  endtask

  // One-cycle write strobe, the write lands at the second edge
  task automatic write_csr(input csr_op_e o, input csr_num_e addr, input logic [31:0] d,
                           input logic [31:0] prior);
    @(posedge clk);
    wr_req <= '{valid: 1'b1, op: o, addr: addr, wdata: d, old_value: prior};
    @(posedge clk);
    wr_req <= '0;
  endtask

  task automatic pulse_trap(input logic save, input logic [31:0] pc);
    @(posedge clk);
    trap_req <= '{save: save, mret: !save,
                  cause: '{interrupt: 1'b0, exception_code: 31'd2}, epc: pc};
    @(posedge clk);
    trap_req <= '0;
  endtask

  task automatic wait_mcycle_running();
    int cycles;
    cycles = 0;
    read_csr(CSR_MCYCLE, CSR_OP_READ);
    while (rd_data == 32'd0) begin
      if (cycles == TIMEOUT) abort_run("Timeout: mcycle never started counting");
      cycles++;
      @(negedge clk);
      rd_data = rdata;
    end
  endtask

  // Stop at the first concurrent assertion failure
  always @(negedge clk) begin
    if (u_csr_file.u_csr_file_sva.error_count != 0) begin
      abort_run("A concurrent assertion in csr_file_sva failed");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    void'($urandom(74));
    clk       = 1'b0;
    rst_n     = 1'b0;
    rd_req    = '0;
    wr_req    = '0;
    trap_req  = '0;
    instr_ret = 1'b0;
    mip       = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    @(negedge clk);
    check_equal("mtvec reset", MTVEC_BASE, mtvec_o);
    check_equal("irq enable reset", 1'b0, m_irq_enable_o);
    check_equal("illegal idle", 1'b0, illegal);
    check_equal("counter_rd idle", 1'b0, counter_rd);

    // Counters held by mcountinhibit, even with retiring instructions
    @(posedge clk);
    instr_ret <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      read_csr(CSR_MCYCLE, CSR_OP_READ);
      check_equal("mcycle stopped", 32'd0, rd_data);
      read_csr(CSR_MINSTRET, CSR_OP_READ);
      check_equal("minstret stopped", 32'd0, rd_data);
    end

    // Every kept address, legal reads
    @(posedge clk);
    mip <= $urandom;
    for (int i = 0; i < 19; i++) begin
      read_csr(KEPT_ADDRS[i], CSR_OP_READ);
      exp_flag = (KEPT_ADDRS[i][11:8] == 4'hB) || (KEPT_ADDRS[i][11:8] == 4'hC);
      check_equal($sformatf("legal read %h", KEPT_ADDRS[i]), 1'b0, rd_illegal);
      check_equal($sformatf("counter flag %h", KEPT_ADDRS[i]), exp_flag, rd_counter);
    end
    read_csr(CSR_MISA, CSR_OP_READ);
    check_equal("misa", MISA_EXP, rd_data);
    read_csr(CSR_MIMPID, CSR_OP_READ);
    check_equal("mimpid", 32'd0, rd_data);
    read_csr(CSR_MTVAL, CSR_OP_READ);
    check_equal("mtval", 32'd0, rd_data);
    read_csr(CSR_MIP, CSR_OP_READ);
    check_equal("mip", mip & IRQ_BITS, rd_data);

    // Unknown addresses and writes to user counters
    for (int i = 0; i < 5; i++) begin
      read_csr(UNKNOWN_ADDRS[i], CSR_OP_READ);
      check_equal($sformatf("unknown %h illegal", UNKNOWN_ADDRS[i]), 1'b1, rd_illegal);
      check_equal($sformatf("unknown %h data", UNKNOWN_ADDRS[i]), 32'd0, rd_data);
    end
    read_csr(CSR_CYCLE, CSR_OP_WRITE);
    check_equal("cycle write illegal", 1'b1, rd_illegal);
    read_csr(CSR_INSTRET, CSR_OP_SET);
    check_equal("instret set illegal", 1'b1, rd_illegal);
    read_csr(CSR_MSCRATCH, CSR_OP_CLEAR);
    check_equal("mscratch clear legal", 1'b0, rd_illegal);

    // mscratch read-modify-write against the model
    model_scratch = '0;
    for (int i = 0; i < 12; i++) begin
      op   = csr_op_e'(2'($urandom_range(3, 1)));
      data = $urandom;
      old  = (i % 2 == 0) ? model_scratch : $urandom;
      write_csr(op, CSR_MSCRATCH, data, old);
      model_scratch = apply_op(op, data, old);
      read_csr(CSR_MSCRATCH, CSR_OP_READ);
      check_equal("mscratch rmw", model_scratch, rd_data);
    end

    // mie keeps the implemented lines only, first access a plain write
    model_mie = '0;
    for (int i = 0; i < 8; i++) begin
      op   = (i == 0) ? CSR_OP_WRITE : csr_op_e'(2'($urandom_range(3, 1)));
      data = $urandom;
      write_csr(op, CSR_MIE, data, model_mie);
      model_mie = apply_op(op, data, model_mie) & IRQ_BITS;
      @(negedge clk);
      check_equal("mie mask", model_mie, mie_o);
    end

    model_inhibit = INHIBIT_BITS;
    for (int i = 0; i < 6; i++) begin
      op   = csr_op_e'(2'($urandom_range(3, 1)));
      data = $urandom;
      write_csr(op, CSR_MCOUNTINHIBIT, data, model_inhibit);
      model_inhibit = apply_op(op, data, model_inhibit) & INHIBIT_BITS;
      read_csr(CSR_MCOUNTINHIBIT, CSR_OP_READ);
      check_equal("mcountinhibit", model_inhibit, rd_data);
    end

    // Trap entry then mret, with the enable on and then off
    for (int i = 0; i < 2; i++) begin
      prev_mie = (i == 0);
      write_csr(CSR_OP_WRITE, CSR_MSTATUS, {28'd0, prev_mie, 3'd0}, 32'd0);
      epc = $urandom;
      pulse_trap(1'b1, epc);
      @(negedge clk);
      check_equal("trap mepc", {epc[31:1], 1'b0}, mepc_o);
      check_equal("trap irq off", 1'b0, m_irq_enable_o);
      pulse_trap(1'b0, 32'd0);
      @(negedge clk);
      check_equal("mret irq restore", prev_mie, m_irq_enable_o);
    end

    // mcycle steps by one per cycle once released
    write_csr(CSR_OP_WRITE, CSR_MCOUNTINHIBIT, 32'd0, 32'd0);
    wait_mcycle_running();
    prev = rd_data;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      check_equal("mcycle step", prev + 32'd1, rdata);
      check_equal("mcycle counter_rd", 1'b1, counter_rd);
      prev = rdata;
    end

    // minstret follows the retire level sampled at each edge
    read_csr(CSR_MINSTRET, CSR_OP_READ);
    for (int i = 0; i < 16; i++) begin
      pending_ret = instr_ret;
      prev        = rdata;
      @(posedge clk);
      instr_ret <= 1'($urandom_range(1));
      @(negedge clk);
      check_equal("minstret step", prev + pending_ret, rdata);
    end

    @(posedge clk);
    rd_req <= '0;
    @(negedge clk);
    if (u_csr_file.u_csr_file_sva.error_count != 0) begin
      abort_run("A concurrent assertion in csr_file_sva failed");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: filelist.f
hdl/csr_pkg.sv
hdl/csr_write_ctrl.sv
hdl/trap_csrs.sv
hdl/hpm_counters.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
verification/csr_file_sva.sv
verification/csr_file_tb.sv
